// File: hw/booth_mul_macros.svh
`ifndef BOOTH_MUL_MACROS_SVH
`define BOOTH_MUL_MACROS_SVH

////////////////////////////////////////////////////////////
// multiplier sizes
////////////////////////////////////////////////////////////

// multiplicand and multiplier width
`define BOOTH_OP_WIDTH 32

// one radix-4 digit per two multiplier bits
`define BOOTH_PP_COUNT 16

// full signed product
`define BOOTH_PROD_WIDTH 64

////////////////////////////////////////////////////////////
// pipeline
////////////////////////////////////////////////////////////

// one register per compressor level, three levels
`define BOOTH_TREE_LATENCY 3

`endif

// File: hw/booth_mul_pkg.sv
`include "booth_mul_macros.svh"

package booth_mul_pkg;

  ////////////////////////////////////////////////////////////
  // radix-4 booth digit
  ////////////////////////////////////////////////////////////

  // bit 2 is the sign, bits 1:0 the magnitude
  typedef enum logic [2:0]
  {
    DIGIT_ZERO = 3'b000, // 000 and 111 windows
    DIGIT_POS1 = 3'b001, // +x
    DIGIT_POS2 = 3'b010, // +2x
    DIGIT_NEG1 = 3'b101, // -x
    DIGIT_NEG2 = 3'b110  // -2x
  } booth_digit_e;

  ////////////////////////////////////////////////////////////
  // data types
  ////////////////////////////////////////////////////////////

  // two's complement operand
  typedef logic signed [`BOOTH_OP_WIDTH-1:0] operand_t;

  // selected multiple, one bit wider than the operand
  typedef logic signed [`BOOTH_OP_WIDTH:0] pp_t;

  // product, also the width of the final sum and carry words
  typedef logic signed [`BOOTH_PROD_WIDTH-1:0] product_t;

endpackage

// File: hw/pp_bus_if.sv
`timescale 1ns/1ps
`include "booth_mul_macros.svh"

// partial products from the booth decoder to the compressor tree
interface pp_bus_if;

  booth_mul_pkg::pp_t         pp    [`BOOTH_PP_COUNT]; // pp[k] has weight 4**k
  booth_mul_pkg::booth_digit_e digit [`BOOTH_PP_COUNT]; // digit behind each pp

  // decoder side
  modport decode_mp
  (
    output pp,
    output digit
  );

  // tree side, digit only needed to tell +2**32 from -2**32
  modport tree_mp
  (
    input pp,
    input digit
  );

endinterface

// File: hw/booth_decode.sv
`timescale 1ns/1ps
`include "booth_mul_macros.svh"

module booth_decode
(
  input  logic                     i_clkp,  // only for the checker below
  input  booth_mul_pkg::operand_t  i_multa, // multiplicand
  input  booth_mul_pkg::operand_t  i_multb, // multiplier
  pp_bus_if.decode_mp              pp_bus
);

  ////////////////////////////////////////////////////////////
  // multiples of the multiplicand
  ////////////////////////////////////////////////////////////

  booth_mul_pkg::pp_t x;         // +x
  booth_mul_pkg::pp_t x_neg;     // -x
  booth_mul_pkg::pp_t x_dbl;     // +2x
  booth_mul_pkg::pp_t x_neg_dbl; // -2x which wraps only for x = -2**31
  logic [`BOOTH_OP_WIDTH:0] y_ext; // multiplier with zero below bit 0

  assign x         = {i_multa[`BOOTH_OP_WIDTH-1], i_multa}; // sign extend
  assign x_neg     = -x;
  assign x_dbl     = x << 1;
  assign x_neg_dbl = x_neg << 1;
  assign y_ext     = {i_multb, 1'b0};

  ////////////////////////////////////////////////////////////
  // recoding and selection per digit
  ////////////////////////////////////////////////////////////

  for (genvar k = 0; k < `BOOTH_PP_COUNT; k++)
  begin : g_digit
    // window y[2k+1], y[2k], y[2k-1]
    always_comb
    begin
      case (y_ext[2*k+2 -: 3])
        3'b001, 3'b010: pp_bus.digit[k] = booth_mul_pkg::DIGIT_POS1;
        3'b011:         pp_bus.digit[k] = booth_mul_pkg::DIGIT_POS2;
        3'b100:         pp_bus.digit[k] = booth_mul_pkg::DIGIT_NEG2;
        3'b101, 3'b110: pp_bus.digit[k] = booth_mul_pkg::DIGIT_NEG1;
        default:        pp_bus.digit[k] = booth_mul_pkg::DIGIT_ZERO; // 000, 111
      endcase
    end

    always_comb
    begin
      case (pp_bus.digit[k])
        booth_mul_pkg::DIGIT_POS1: pp_bus.pp[k] = x;
        booth_mul_pkg::DIGIT_POS2: pp_bus.pp[k] = x_dbl;
        booth_mul_pkg::DIGIT_NEG1: pp_bus.pp[k] = x_neg;
        booth_mul_pkg::DIGIT_NEG2: pp_bus.pp[k] = x_neg_dbl;
        default:                   pp_bus.pp[k] = '0;
      endcase
    end

    // a uniform window is the zero digit and must not leak multiplicand bits
    a_zero_digit : assert property (@(posedge i_clkp)
      (y_ext[2*k+2 -: 3] == 3'b000 || y_ext[2*k+2 -: 3] == 3'b111) |->
        (pp_bus.digit[k] == booth_mul_pkg::DIGIT_ZERO && pp_bus.pp[k] == '0));
  end

endmodule

// File: hw/compressor_4to2.sv
`timescale 1ns/1ps

// four words in, sum and carry word out
// o_c sits one bit above o_d, so y+z+a+b = o_d + 2*o_c
module compressor_4to2
#(
  parameter int WIDTH = 40
)
(
  input  logic [WIDTH-1:0] i_y,
  input  logic [WIDTH-1:0] i_z,
  input  logic [WIDTH-1:0] i_a,
  input  logic [WIDTH-1:0] i_b,
  output logic [WIDTH-1:0] o_d, // sum word
  output logic [WIDTH-1:0] o_c  // carry word, weight x2
);

  logic [WIDTH-1:0] s1;    // first full adder sum
  logic [WIDTH-1:0] chain; // first full adder carry, goes to next bit
  logic [WIDTH-1:0] cin;   // chain into the second full adder

  // chain out of the top bit is dropped
  assign cin = {chain[WIDTH-2:0], 1'b0};

  for (genvar i = 0; i < WIDTH; i++)
  begin : g_bit
    // full adder 1: y, z, a
    assign s1[i]    = i_y[i] ^ i_z[i] ^ i_a[i];
    assign chain[i] = (i_y[i] & i_z[i]) | (i_y[i] & i_a[i]) | (i_z[i] & i_a[i]);

    // full adder 2: s1, b, incoming chain
    assign o_d[i] = s1[i] ^ i_b[i] ^ cin[i];
    assign o_c[i] = (s1[i] & i_b[i]) | (s1[i] & cin[i]) | (i_b[i] & cin[i]);
  end

endmodule

// File: hw/csa_tree.sv
`timescale 1ns/1ps
`include "booth_mul_macros.svh"

module csa_tree
(
  input  logic                     i_clkp,
  input  logic                     i_reset,
  pp_bus_if.tree_mp                pp_bus,
  output booth_mul_pkg::product_t  o_sum,   // final sum word
  output booth_mul_pkg::product_t  o_carry  // final carry word already at true weight
);

  // level widths wide enough that y/z/a keep two sign bits
  // and b keeps one so the output words sign extend exactly
  localparam int PP_W   = `BOOTH_OP_WIDTH + 1;  // 33
  localparam int EXT_W  = PP_W + 1;             // +2**32 needs one more bit
  localparam int L1_W   = EXT_W + 6;            // 4 pps at 2-bit spacing
  localparam int L2_W   = L1_W + 9;             // 2 groups at 8-bit spacing
  localparam int L3_W   = `BOOTH_PROD_WIDTH;
  localparam int L1_CNT = `BOOTH_PP_COUNT / 4;
  localparam int L2_CNT = L1_CNT / 2;

  logic [EXT_W-1:0] pp_ext [`BOOTH_PP_COUNT]; // pp with its true sign on top
  logic             pp_all_zero;
  logic             out_zero;

  ////////////////////////////////////////////////////////////
  // sign of each partial product
  ////////////////////////////////////////////////////////////

  // -2x of x = -2**31 wraps to the pattern of -2**32
  for (genvar k = 0; k < `BOOTH_PP_COUNT; k++)
  begin : g_ext
    logic wrap;
    assign wrap = (pp_bus.digit[k] == booth_mul_pkg::DIGIT_NEG2) &&
                  (pp_bus.pp[k][PP_W-2:0] == '0);
    assign pp_ext[k] = {pp_bus.pp[k][PP_W-1] & ~wrap, pp_bus.pp[k]};
  end

  always_comb
  begin
    pp_all_zero = 1'b1;
    for (int k = 0; k < `BOOTH_PP_COUNT; k++)
    begin
      if (pp_bus.pp[k] != '0)
        pp_all_zero = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // level 1 reduces 16 pps to 4 sum/carry pairs
  ////////////////////////////////////////////////////////////

  logic [L1_W-1:0] l1_in  [L1_CNT][4];
  logic [L1_W-1:0] l1_d   [L1_CNT];
  logic [L1_W-1:0] l1_c   [L1_CNT];
  logic [L1_W-1:0] l1_d_q [L1_CNT];
  logic [L1_W-1:0] l1_c_q [L1_CNT];

  for (genvar g = 0; g < L1_CNT; g++)
  begin : g_l1
    for (genvar j = 0; j < 4; j++)
    begin : g_in
      // pp 4g+j at weight 4**j inside the group
      assign l1_in[g][j] = {{(L1_W-EXT_W){pp_ext[4*g+j][EXT_W-1]}}, pp_ext[4*g+j]} << (2*j);
    end

    compressor_4to2 #(.WIDTH(L1_W)) u_cmp
    (
      .i_y (l1_in[g][0]),
      .i_z (l1_in[g][1]),
      .i_a (l1_in[g][2]),
      .i_b (l1_in[g][3]), // widest shift on b with only one sign bit
      .o_d (l1_d[g]),
      .o_c (l1_c[g])
    );
  end

  always_ff @(posedge i_clkp)
  begin
    for (int g = 0; g < L1_CNT; g++)
    begin
      if (i_reset)
      begin
        l1_d_q[g] <= '0;
        l1_c_q[g] <= '0;
      end
      else
      begin
        l1_d_q[g] <= l1_d[g];
        l1_c_q[g] <= l1_c[g];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // level 2 reduces 8 words to 2 sum/carry pairs
  ////////////////////////////////////////////////////////////

  logic [L2_W-1:0] l2_d   [L2_CNT];
  logic [L2_W-1:0] l2_c   [L2_CNT];
  logic [L2_W-1:0] l2_d_q [L2_CNT];
  logic [L2_W-1:0] l2_c_q [L2_CNT];

  for (genvar h = 0; h < L2_CNT; h++)
  begin : g_l2
    logic [L2_W-1:0] y, z, a, b;

    assign y = {{(L2_W-L1_W){l1_d_q[2*h][L1_W-1]}}, l1_d_q[2*h]};
    assign z = {{(L2_W-L1_W){l1_c_q[2*h][L1_W-1]}}, l1_c_q[2*h]} << 1;   // carry weight
    assign a = {{(L2_W-L1_W){l1_d_q[2*h+1][L1_W-1]}}, l1_d_q[2*h+1]} << 8; // next group
    assign b = {{(L2_W-L1_W){l1_c_q[2*h+1][L1_W-1]}}, l1_c_q[2*h+1]} << 9;

    compressor_4to2 #(.WIDTH(L2_W)) u_cmp
    (
      .i_y (y),
      .i_z (z),
      .i_a (a),
      .i_b (b),
      .o_d (l2_d[h]),
      .o_c (l2_c[h])
    );
  end

  always_ff @(posedge i_clkp)
  begin
    for (int h = 0; h < L2_CNT; h++)
    begin
      if (i_reset)
      begin
        l2_d_q[h] <= '0;
        l2_c_q[h] <= '0;
      end
      else
      begin
        l2_d_q[h] <= l2_d[h];
        l2_c_q[h] <= l2_c[h];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // level 3 reduces 4 words to the final pair mod 2**64
  ////////////////////////////////////////////////////////////

  logic [L3_W-1:0] l3_y, l3_z, l3_a, l3_b;
  logic [L3_W-1:0] l3_d, l3_c;
  logic [L3_W-1:0] l3_d_q, l3_c_q;

  assign l3_y = {{(L3_W-L2_W){l2_d_q[0][L2_W-1]}}, l2_d_q[0]};
  assign l3_z = {{(L3_W-L2_W){l2_c_q[0][L2_W-1]}}, l2_c_q[0]} << 1;
  assign l3_a = {{(L3_W-L2_W){l2_d_q[1][L2_W-1]}}, l2_d_q[1]} << 16; // upper half at 4**8
  assign l3_b = {{(L3_W-L2_W){l2_c_q[1][L2_W-1]}}, l2_c_q[1]} << 17;

  compressor_4to2 #(.WIDTH(L3_W)) u_cmp_l3
  (
    .i_y (l3_y),
    .i_z (l3_z),
    .i_a (l3_a),
    .i_b (l3_b),
    .o_d (l3_d),
    .o_c (l3_c)
  );

  always_ff @(posedge i_clkp)
  begin
    if (i_reset)
    begin
      l3_d_q <= '0;
      l3_c_q <= '0;
    end
    else
    begin
      l3_d_q <= l3_d;
      l3_c_q <= l3_c;
    end
  end

  assign o_sum   = l3_d_q;
  assign o_carry = {l3_c_q[L3_W-2:0], 1'b0}; // carry at its true weight

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  assign out_zero = (o_sum == '0) && (o_carry == '0);

  // a reset flushes every level so the outputs stay zero for three cycles
  a_reset_clears : assert property (@(posedge i_clkp)
    i_reset |=> out_zero ##1 out_zero ##1 out_zero);

  // zero partial products reach the output as zero words after the full latency
  a_zero_flow : assert property (@(posedge i_clkp) disable iff (i_reset)
    pp_all_zero |-> ##(`BOOTH_TREE_LATENCY) out_zero);

endmodule

// File: hw/final_adder.sv
`timescale 1ns/1ps
`include "booth_mul_macros.svh"

module final_adder
(
  input  booth_mul_pkg::product_t i_sum,
  input  booth_mul_pkg::product_t i_carry,
  output booth_mul_pkg::product_t o_product
);

  localparam int GRP_CNT = `BOOTH_PROD_WIDTH / 4; // 4-bit groups

  logic [`BOOTH_PROD_WIDTH-1:0] g;  // bit generate
  logic [`BOOTH_PROD_WIDTH-1:0] p;  // bit propagate
  logic [`BOOTH_PROD_WIDTH-1:0] c;  // carry into each bit
  logic [GRP_CNT-1:0]           gg; // group generate
  logic [GRP_CNT-1:0]           gp; // group propagate
  logic [GRP_CNT-1:0]           gc; // carry into each group

  assign g = i_sum & i_carry;
  assign p = i_sum ^ i_carry;

  always_comb
  begin
    // group g/p from the four bits
    for (int j = 0; j < GRP_CNT; j++)
    begin
      gg[j] = g[4*j+3] | (p[4*j+3] & g[4*j+2]) |
              (p[4*j+3] & p[4*j+2] & g[4*j+1]) |
              (p[4*j+3] & p[4*j+2] & p[4*j+1] & g[4*j]);
      gp[j] = &p[4*j +: 4];
    end

    // lookahead over the groups, carry out of the top is dropped
    gc[0] = 1'b0;
    for (int j = 1; j < GRP_CNT; j++)
      gc[j] = gg[j-1] | (gp[j-1] & gc[j-1]);

    // carries inside each group
    for (int j = 0; j < GRP_CNT; j++)
    begin
      c[4*j] = gc[j];
      for (int k = 1; k < 4; k++)
        c[4*j+k] = g[4*j+k-1] | (p[4*j+k-1] & c[4*j+k-1]);
    end
  end

  assign o_product = p ^ c;

endmodule

// File: hw/booth_mul32.sv
`timescale 1ns/1ps
`include "booth_mul_macros.svh"

module booth_mul32
(
  input  logic                          i_clkp,
  input  logic                          i_reset,
  input  logic [`BOOTH_OP_WIDTH-1:0]    i_multa,   // multiplicand, signed
  input  logic [`BOOTH_OP_WIDTH-1:0]    i_multb,   // multiplier, signed
  output logic [`BOOTH_PROD_WIDTH-1:0]  o_product  // 3 cycles after the operands
);

  booth_mul_pkg::product_t sum_word;
  booth_mul_pkg::product_t carry_word;

  pp_bus_if pp_bus ();

  // recode and select, combinational
  booth_decode u_decode
  (
    .i_clkp  (i_clkp),
    .i_multa (i_multa),
    .i_multb (i_multb),
    .pp_bus  (pp_bus)
  );

  // three registered compressor levels
  csa_tree u_tree
  (
    .i_clkp  (i_clkp),
    .i_reset (i_reset),
    .pp_bus  (pp_bus),
    .o_sum   (sum_word),
    .o_carry (carry_word)
  );

  // carry-propagate add of the last pair
  final_adder u_adder
  (
    .i_sum     (sum_word),
    .i_carry   (carry_word),
    .o_product (o_product)
  );

endmodule

// File: bench/tb_booth_mul32.sv
`timescale 1ns/1ps
`include "booth_mul_macros.svh"

module tb_booth_mul32;

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 4;
  localparam int LATENCY         = `BOOTH_TREE_LATENCY;
  localparam int TABLE_LEN       = 21;
  localparam int RANDOM_COUNT    = 200;
  localparam int RESET_AT        = 100; // random index that carries the reset pulse
  localparam int WATCHDOG_CYCLES = TABLE_LEN + RANDOM_COUNT + 20;

  // one operation with its operands and product
  typedef struct packed
  {
    logic [`BOOTH_OP_WIDTH-1:0]   a;
    logic [`BOOTH_OP_WIDTH-1:0]   b;
    logic [`BOOTH_PROD_WIDTH-1:0] exp;
  } vec_t;

  ////////////////////////////////////////////////////////////
  // directed vectors with products worked out by hand
  ////////////////////////////////////////////////////////////

  localparam vec_t VECTORS [TABLE_LEN] = '{
    {32'h00000000, 32'h12345678, 64'h0000000000000000}, // 0 * x
    {32'h9ABCDEF0, 32'h00000000, 64'h0000000000000000}, // x * 0
    {32'hFFFFFFFF, 32'hFFFFFFFF, 64'h0000000000000001}, // -1 * -1
    {32'h80000000, 32'h80000000, 64'h4000000000000000}, // min squared
    {32'h7FFFFFFF, 32'h80000000, 64'hC000000080000000}, // max * min
    {32'h00000001, 32'h87654321, 64'hFFFFFFFF87654321}, // 1 * negative
    {32'h87654321, 32'h00000001, 64'hFFFFFFFF87654321},
    {32'h00000001, 32'h12345678, 64'h0000000012345678}, // 1 * positive
    {32'h7FFFFFFF, 32'h7FFFFFFF, 64'h3FFFFFFF00000001}, // max squared
    {32'h80000000, 32'hFFFFFFFF, 64'h0000000080000000}, // -x of min
    {32'h80000000, 32'h00000002, 64'hFFFFFFFF00000000}, // -2x of min wraps
    // booth digit patterns against a positive multiplicand
    {32'h00000003, 32'h55555555, 64'h00000000FFFFFFFF},
    {32'h00000003, 32'hAAAAAAAA, 64'hFFFFFFFEFFFFFFFE},
    {32'h00000003, 32'h33333333, 64'h0000000099999999},
    {32'h00000003, 32'hCCCCCCCC, 64'hFFFFFFFF66666664},
    {32'h00000003, 32'h7FFFFFFF, 64'h000000017FFFFFFD},
    // same patterns against a negative multiplicand
    {32'hFFFFFFFB, 32'h55555555, 64'hFFFFFFFE55555557},
    {32'hFFFFFFFB, 32'hAAAAAAAA, 64'h00000001AAAAAAAE},
    {32'hFFFFFFFB, 32'h33333333, 64'hFFFFFFFF00000001},
    {32'hFFFFFFFB, 32'hCCCCCCCC, 64'h0000000100000004},
    {32'hFFFFFFFB, 32'h7FFFFFFF, 64'hFFFFFFFD80000005}
  };

  logic                         clk;
  logic                         reset;
  logic [`BOOTH_OP_WIDTH-1:0]   multa;
  logic [`BOOTH_OP_WIDTH-1:0]   multb;
  logic [`BOOTH_PROD_WIDTH-1:0] product;

  integer seed;
  vec_t   sb_queue [$]; // one entry per driven cycle with the oldest at the front

  booth_mul32 booth_mul32_i
  (
    .i_clkp    (clk),
    .i_reset   (reset),
    .i_multa   (multa),
    .i_multb   (multb),
    .o_product (product)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // low 64 bits of the two's complement product
  function automatic logic [63:0] signed_product(input logic [31:0] a, input logic [31:0] b);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    a_ext = {{32{a[31]}}, a};
    b_ext = {{32{b[31]}}, b};
    return a_ext * b_ext;
  endfunction

  task automatic check_equal(input logic [63:0] got, input logic [63:0] expected,
                             input vec_t v);
    if (got !== expected)
    begin
      $display("[FAIL] %0t ns: a=%h b=%h got %h expected %h",
               $time, v.a, v.b, got, expected);
      $display("Result: FAILED");
      $fatal(1, "product mismatch");
    end
  endtask

  // one cycle of stimulus where rst high flushes what the tree holds
  task automatic apply_vector(input vec_t v, input logic rst);
    vec_t e;
    @(posedge clk);
    multa <= v.a;
    multb <= v.b;
    reset <= rst;
    sb_queue.push_back(v);
    if (rst)
    begin
      // this entry and the two before it never reach the output
      for (int i = sb_queue.size() - LATENCY; i < sb_queue.size(); i++)
      begin
        e        = sb_queue[i];
        e.exp    = '0;
        sb_queue[i] = e;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // scoreboard sampling on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin : monitor
    vec_t entry;
    if (sb_queue.size() > LATENCY)
    begin
      entry = sb_queue.pop_front(); // driven LATENCY edges ago
      check_equal(product, entry.exp, entry);
    end
  end

  initial
  begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin : driver
    vec_t        v;
    logic [31:0] ra;
    logic [31:0] rb;

    reset <= 1'b1;
    multa <= '0;
    multb <= '0;
    seed  = 74608;

    // tree contents before the first reset edge which clears them
    repeat (LATENCY) sb_queue.push_back('0);

    // reset seen at RESET_CYCLES edges
    repeat (RESET_CYCLES - 1) apply_vector('0, 1'b1);

    // zero operands right after reset
    repeat (LATENCY) apply_vector('0, 1'b0);

    for (int n = 0; n < TABLE_LEN; n++)
      apply_vector(VECTORS[n], 1'b0);

    // back to back random traffic with one reset pulse inside
    for (int n = 0; n < RANDOM_COUNT; n++)
    begin
      ra    = $random(seed);
      rb    = $random(seed);
      v.a   = ra;
      v.b   = rb;
      v.exp = signed_product(ra, rb);
      apply_vector(v, (n == RESET_AT));
    end

    // drain the pipe
    repeat (LATENCY) apply_vector('0, 1'b0);
    @(posedge clk);

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: booth_mul32.f
+incdir+hw
hw/booth_mul_pkg.sv
hw/pp_bus_if.sv
hw/booth_decode.sv
hw/compressor_4to2.sv
hw/csa_tree.sv
hw/final_adder.sv
hw/booth_mul32.sv
bench/tb_booth_mul32.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the booth multiplier testbench with verilator
set -e

cd "$(dirname "$0")"

TOP=tb_booth_mul32
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -f booth_mul32.f -o "V$TOP"

# the log decides pass or fail
./obj_dir/"V$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
  echo "simulation ended without a result, see $LOG"
  exit 1
fi
echo "simulation passed"
